//--- verilog/clint_defines.svh
`ifndef CLINT_DEFINES_SVH
`define CLINT_DEFINES_SVH

// CLINT window in the system address map
`define CLINT_BASE 32'h0200_0000
`define CLINT_SPAN 32'h0001_0000

// register offsets relative to CLINT_BASE
`define CLINT_MSIP_OFS        16'h0000
`define CLINT_MTIMECMP_LO_OFS 16'h4000
`define CLINT_MTIMECMP_HI_OFS 16'h4004
`define CLINT_MTIME_LO_OFS    16'hBFF8
`define CLINT_MTIME_HI_OFS    16'hBFFC

// AXI4-Lite response codes
`define CLINT_RESP_OKAY   2'b00
`define CLINT_RESP_SLVERR 2'b10

`endif

//--- verilog/clint_axi_pkg.sv
`default_nettype none

package clint_axi_pkg;

    // read address channel payload
    typedef struct packed {
        logic [31:0] addr;
    } ar_chan_t;

    // write address channel payload
    typedef struct packed {
        logic [31:0] addr;
    } aw_chan_t;

    // write data channel payload
    typedef struct packed {
        logic [31:0] data;
        logic [3:0]  strb; // one bit per byte lane
    } w_chan_t;

    // read response channel payload
    typedef struct packed {
        logic [31:0] data;
        logic [1:0]  resp;
    } r_chan_t;

    // write response channel payload
    typedef struct packed {
        logic [1:0] resp;
    } b_chan_t;

endpackage

`default_nettype wire

//--- verilog/clint_reg_pkg.sv
`default_nettype none

package clint_reg_pkg;

    // register selected by the address decoder
    typedef enum logic [2:0] {
        REG_MSIP,
        REG_MTIMECMP_LO,
        REG_MTIMECMP_HI,
        REG_MTIME_LO,
        REG_MTIME_HI,
        REG_NONE
    } clint_reg_e;

    // one register access from the bus side
    typedef struct packed {
        logic        valid;
        logic        write;
        clint_reg_e  sel;
        logic [31:0] wdata;
        logic [3:0]  wstrb;
    } reg_req_t;

    // result of the access in the same cycle
    typedef struct packed {
        logic [31:0] rdata;
        logic        err; // set for an unmapped offset
    } reg_rsp_t;

endpackage

`default_nettype wire

//--- verilog/clint_chan_buf.sv
`timescale 1ns/1ps
`default_nettype none

module clint_chan_buf #(
    parameter type T = logic [31:0]
) (
    input  wire  clk,
    input  wire  rst,

    input  wire  in_valid,
    output logic in_ready,
    input  T     in_data,

    output logic out_valid,
    input  wire  out_ready,
    output T     out_data
);

    logic full;
    T     data_q;

    // a full slot can take a new beat while the old one leaves
    assign in_ready  = !full || out_ready;
    assign out_valid = full;
    assign out_data  = data_q;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            full <= 1'b0;
        end else if (in_valid && in_ready) begin
            full <= 1'b1;
        end else if (out_ready) begin
            full <= 1'b0; // drained with nothing behind it
        end
    end

    always_ff @(posedge clk) begin
        if (in_valid && in_ready) begin
            data_q <= in_data;
        end
    end

endmodule

`default_nettype wire

//--- verilog/clint_axi_slave.sv
`timescale 1ns/1ps
`default_nettype none

`include "clint_defines.svh"

module clint_axi_slave
    import clint_axi_pkg::*;
    import clint_reg_pkg::*;
(
    input  wire      clk,
    input  wire      rst,

    input  wire      ar_valid,
    output logic     ar_ready,
    input  ar_chan_t ar,

    input  wire      aw_valid,
    output logic     aw_ready,
    input  aw_chan_t aw,

    input  wire      w_valid,
    output logic     w_ready,
    input  w_chan_t  w,

    output logic     r_valid,
    input  wire      r_ready,
    output r_chan_t  r,

    output logic     b_valid,
    input  wire      b_ready,
    output b_chan_t  b,

    output reg_req_t req,
    input  reg_rsp_t rsp
);

    typedef enum logic [1:0] {
        IDLE,
        READ_RSP,
        WRITE_DATA,
        WRITE_RSP
    } state_e;

    state_e      state;
    logic        req_valid;
    logic        req_write;
    clint_reg_e  req_sel;
    logic [31:0] req_wdata;
    logic [3:0]  req_wstrb;

    // map a bus address onto one of the CLINT registers
    function automatic clint_reg_e decode(input logic [31:0] addr);
        logic [31:0] offset;
        clint_reg_e  sel;
        offset = addr - `CLINT_BASE;
        sel    = REG_NONE;
        if (offset < `CLINT_SPAN) begin // addresses below the base wrap high
            case (offset[15:0])
                `CLINT_MSIP_OFS:        sel = REG_MSIP;
                `CLINT_MTIMECMP_LO_OFS: sel = REG_MTIMECMP_LO;
                `CLINT_MTIMECMP_HI_OFS: sel = REG_MTIMECMP_HI;
                `CLINT_MTIME_LO_OFS:    sel = REG_MTIME_LO;
                `CLINT_MTIME_HI_OFS:    sel = REG_MTIME_HI;
                default:                sel = REG_NONE;
            endcase
        end
        return sel;
    endfunction

    assign ar_ready = (state == IDLE);
    assign aw_ready = (state == IDLE) && !ar_valid; // reads win over writes
    assign w_ready  = (state == WRITE_DATA);

    assign req = '{valid: req_valid, write: req_write, sel: req_sel,
                   wdata: req_wdata, wstrb: req_wstrb};

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state     <= IDLE;
            req_valid <= 1'b0;
            r_valid   <= 1'b0;
            b_valid   <= 1'b0;
        end else begin
            case (state)
                IDLE: begin
                    if (ar_valid) begin
                        req_valid <= 1'b1;
                        state     <= READ_RSP;
                    end else if (aw_valid) begin
                        state <= WRITE_DATA;
                    end
                end
                READ_RSP: begin
                    if (!r_valid) begin
                        r_valid   <= 1'b1; // data sampled from the timer block
                        req_valid <= 1'b0;
                    end else if (r_ready) begin
                        r_valid <= 1'b0;
                        state   <= IDLE;
                    end
                end
                WRITE_DATA: begin
                    if (w_valid) begin
                        req_valid <= 1'b1;
                        state     <= WRITE_RSP;
                    end
                end
                WRITE_RSP: begin
                    if (!b_valid) begin
                        b_valid   <= 1'b1; // register updates on this same edge
                        req_valid <= 1'b0;
                    end else if (b_ready) begin
                        b_valid <= 1'b0;
                        state   <= IDLE;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == IDLE && ar_valid) begin
            req_write <= 1'b0;
            req_sel   <= decode(ar.addr);
        end else if (state == IDLE && aw_valid) begin
            req_write <= 1'b1;
            req_sel   <= decode(aw.addr);
        end
        if (state == WRITE_DATA && w_valid) begin
            req_wdata <= w.data;
            req_wstrb <= w.strb;
        end
        if (state == READ_RSP && !r_valid) begin
            r.data <= rsp.rdata;
            r.resp <= rsp.err ? `CLINT_RESP_SLVERR : `CLINT_RESP_OKAY;
        end
        if (state == WRITE_RSP && !b_valid) begin
            b.resp <= rsp.err ? `CLINT_RESP_SLVERR : `CLINT_RESP_OKAY;
        end
    end

endmodule

`default_nettype wire

//--- verilog/clint_timer.sv
`timescale 1ns/1ps
`default_nettype none

module clint_timer
    import clint_reg_pkg::*;
(
    input  wire      clk,
    input  wire      rst,

    input  reg_req_t req,
    output reg_rsp_t rsp,

    output logic     mtip,
    output logic     msip
);

    logic [63:0] mtime;
    logic [63:0] mtimecmp;
    logic        msip_q;
    logic        wr;

    // byte lanes with their strobe set take the new data
    function automatic logic [31:0] merge(input logic [31:0] old,
                                          input logic [31:0] data,
                                          input logic [3:0]  strb);
        logic [31:0] res;
        for (int i = 0; i < 4; i++) begin
            res[8*i +: 8] = strb[i] ? data[8*i +: 8] : old[8*i +: 8];
        end
        return res;
    endfunction

    assign wr = req.valid && req.write;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            mtime <= '0;
        end else if (wr && req.sel == REG_MTIME_LO) begin
            mtime[31:0] <= merge(mtime[31:0], req.wdata, req.wstrb);
        end else if (wr && req.sel == REG_MTIME_HI) begin
            mtime[63:32] <= merge(mtime[63:32], req.wdata, req.wstrb);
        end else begin
            mtime <= mtime + 64'd1; // free running on every clock
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            mtimecmp <= '1; // keeps mtip low out of reset
        end else if (wr && req.sel == REG_MTIMECMP_LO) begin
            mtimecmp[31:0] <= merge(mtimecmp[31:0], req.wdata, req.wstrb);
        end else if (wr && req.sel == REG_MTIMECMP_HI) begin
            mtimecmp[63:32] <= merge(mtimecmp[63:32], req.wdata, req.wstrb);
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            msip_q <= 1'b0;
        end else if (wr && req.sel == REG_MSIP && req.wstrb[0]) begin
            msip_q <= req.wdata[0];
        end
    end

    always_comb begin
        case (req.sel)
            REG_MSIP:        rsp.rdata = {31'b0, msip_q};
            REG_MTIMECMP_LO: rsp.rdata = mtimecmp[31:0];
            REG_MTIMECMP_HI: rsp.rdata = mtimecmp[63:32];
            REG_MTIME_LO:    rsp.rdata = mtime[31:0];
            REG_MTIME_HI:    rsp.rdata = mtime[63:32];
            default:         rsp.rdata = 32'b0; // unmapped reads as zero
        endcase
        rsp.err = (req.sel == REG_NONE);
    end

    assign mtip = (mtime >= mtimecmp);
    assign msip = msip_q;

endmodule

`default_nettype wire

//--- verilog/clint_top.sv
`timescale 1ns/1ps
`default_nettype none

module clint_top
    import clint_axi_pkg::*;
    import clint_reg_pkg::*;
(
    input  wire      clk,
    input  wire      rst,

    input  wire      ar_valid,
    output logic     ar_ready,
    input  ar_chan_t ar,

    input  wire      aw_valid,
    output logic     aw_ready,
    input  aw_chan_t aw,

    input  wire      w_valid,
    output logic     w_ready,
    input  w_chan_t  w,

    output logic     r_valid,
    input  wire      r_ready,
    output r_chan_t  r,

    output logic     b_valid,
    input  wire      b_ready,
    output b_chan_t  b,

    output logic     mtip,
    output logic     msip
);

    logic     ar_buf_valid;
    logic     ar_buf_ready;
    ar_chan_t ar_buf;
    logic     aw_buf_valid;
    logic     aw_buf_ready;
    aw_chan_t aw_buf;
    reg_req_t req;
    reg_rsp_t rsp;

    clint_chan_buf #(.T(ar_chan_t)) u_ar_buf (
        .clk(clk), .rst(rst),
        .in_valid(ar_valid), .in_ready(ar_ready), .in_data(ar),
        .out_valid(ar_buf_valid), .out_ready(ar_buf_ready), .out_data(ar_buf)
    );

    clint_chan_buf #(.T(aw_chan_t)) u_aw_buf (
        .clk(clk), .rst(rst),
        .in_valid(aw_valid), .in_ready(aw_ready), .in_data(aw),
        .out_valid(aw_buf_valid), .out_ready(aw_buf_ready), .out_data(aw_buf)
    );

    clint_axi_slave u_slave (
        .clk(clk), .rst(rst),
        .ar_valid(ar_buf_valid), .ar_ready(ar_buf_ready), .ar(ar_buf),
        .aw_valid(aw_buf_valid), .aw_ready(aw_buf_ready), .aw(aw_buf),
        .w_valid(w_valid), .w_ready(w_ready), .w(w),
        .r_valid(r_valid), .r_ready(r_ready), .r(r),
        .b_valid(b_valid), .b_ready(b_ready), .b(b),
        .req(req), .rsp(rsp)
    );

    clint_timer u_timer (
        .clk(clk), .rst(rst),
        .req(req), .rsp(rsp),
        .mtip(mtip), .msip(msip)
    );

endmodule

`default_nettype wire

//--- dv/clint_properties.sv
`timescale 1ns/1ps
`default_nettype none

module clint_properties
    import clint_axi_pkg::*;
(
    input wire         clk,
    input wire         rst,
    input wire         ar_ready,
    input wire         aw_ready,
    input wire         w_ready,
    input wire         r_valid,
    input wire         r_ready,
    input r_chan_t     r,
    input wire         b_valid,
    input wire         b_ready,
    input b_chan_t     b,
    input wire         mtip,
    input wire         msip,
    input wire  [63:0] mtime,
    input wire  [63:0] mtimecmp
);

    // a stalled read response keeps its data until r_ready
    r_hold: assert property (@(posedge clk) disable iff (rst)
        r_valid && !r_ready |=> r_valid && $stable(r))
        else $error("read response changed while stalled");

    b_hold: assert property (@(posedge clk) disable iff (rst)
        b_valid && !b_ready |=> b_valid && $stable(b))
        else $error("write response changed while stalled");

    reset_outputs: assert property (@(posedge clk)
        rst |-> !r_valid && !b_valid && ar_ready && aw_ready && !w_ready && !mtip && !msip)
        else $error("outputs not at reset values");

    // timer interrupt rises on the edge where a counting mtime reaches mtimecmp
    mtip_compare: assert property (@(posedge clk) disable iff (rst)
        $stable(mtimecmp) && mtime == $past(mtime) + 64'd1 && mtime == mtimecmp
        |-> mtip && !$past(mtip))
        else $error("mtip did not rise when mtime reached mtimecmp");

endmodule

bind clint_top clint_properties u_props (
    .clk(clk), .rst(rst),
    .ar_ready(ar_ready), .aw_ready(aw_ready), .w_ready(w_ready),
    .r_valid(r_valid), .r_ready(r_ready), .r(r),
    .b_valid(b_valid), .b_ready(b_ready), .b(b),
    .mtip(mtip), .msip(msip),
    .mtime(u_timer.mtime), .mtimecmp(u_timer.mtimecmp)
);

`default_nettype wire

//--- dv/clint_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "clint_defines.svh"

module clint_tb
    import clint_axi_pkg::*;
();

    localparam int TIMEOUT = 64;
    localparam int SEED    = 9;

    localparam logic [31:0] A_MSIP   = `CLINT_BASE | {16'h0, `CLINT_MSIP_OFS};
    localparam logic [31:0] A_CMP_LO = `CLINT_BASE | {16'h0, `CLINT_MTIMECMP_LO_OFS};
    localparam logic [31:0] A_CMP_HI = `CLINT_BASE | {16'h0, `CLINT_MTIMECMP_HI_OFS};
    localparam logic [31:0] A_MT_LO  = `CLINT_BASE | {16'h0, `CLINT_MTIME_LO_OFS};
    localparam logic [31:0] A_MT_HI  = `CLINT_BASE | {16'h0, `CLINT_MTIME_HI_OFS};

    logic     clk;
    logic     rst;
    logic     ar_valid, ar_ready, aw_valid, aw_ready, w_valid, w_ready;
    logic     r_valid, r_ready, b_valid, b_ready, mtip, msip;
    ar_chan_t ar;
    aw_chan_t aw;
    w_chan_t  w;
    r_chan_t  r;
    b_chan_t  b;

    logic [63:0] sh_cmp;
    logic        sh_msip;
    logic [31:0] rd_data;
    logic [1:0]  rd_resp;
    logic [31:0] val;
    logic [31:0] addr;
    logic [31:0] v1;
    logic [33:0] pred;
    int          cnt;

    clint_top i_clint_top (.*);

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    task automatic stop_run(input string msg);
        $display("%s", msg);
        $display("*** TEST FAILED ***");
        $fatal(1);
    endtask

    task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            $display("[ERROR] %s: got 0x%0h, expected 0x%0h", name, got, exp);
            stop_run("value mismatch");
        end
    endtask

    // expected {data, resp} for a read; mtime data is not predicted
    function automatic logic [33:0] ref_reg(input logic [31:0] a);
        case (a)
            A_MSIP:   return {31'b0, sh_msip, `CLINT_RESP_OKAY};
            A_CMP_LO: return {sh_cmp[31:0], `CLINT_RESP_OKAY};
            A_CMP_HI: return {sh_cmp[63:32], `CLINT_RESP_OKAY};
            A_MT_LO:  return {32'b0, `CLINT_RESP_OKAY};
            A_MT_HI:  return {32'b0, `CLINT_RESP_OKAY};
            default:  return {32'b0, `CLINT_RESP_SLVERR};
        endcase
    endfunction

    task automatic ref_write(input logic [31:0] a, input logic [31:0] d, input logic [3:0] s);
        logic [31:0] m;
        m = {{8{s[3]}}, {8{s[2]}}, {8{s[1]}}, {8{s[0]}}};
        if (a == A_CMP_LO) sh_cmp[31:0] = (sh_cmp[31:0] & ~m) | (d & m);
        if (a == A_CMP_HI) sh_cmp[63:32] = (sh_cmp[63:32] & ~m) | (d & m);
        if (a == A_MSIP && s[0]) sh_msip = d[0];
    endtask

    task automatic axi_read(input logic [31:0] a, output logic [31:0] d, output logic [1:0] rs);
        int n;
        int hold;
        bit done;
        hold = $urandom % 6; // response back-pressure
        @(posedge clk);
        ar_valid <= 1'b1;
        ar.addr  <= a;
        n = 0;
        done = 1'b0;
        while (!done) begin
            @(negedge clk);
            done = ar_ready;
            @(posedge clk);
            if (done) ar_valid <= 1'b0;
            n++;
            if (!done && n > TIMEOUT) stop_run("timeout waiting for ar_ready");
        end
        n = 0;
        while (!r_valid) begin
            @(negedge clk);
            n++;
            if (n > TIMEOUT) stop_run("timeout waiting for r_valid");
        end
        repeat (hold) @(posedge clk);
        @(posedge clk);
        r_ready <= 1'b1;
        @(negedge clk);
        d  = r.data;
        rs = r.resp;
        @(posedge clk);
        r_ready <= 1'b0;
    endtask

    task automatic axi_write(input logic [31:0] a, input logic [31:0] d, input logic [3:0] s);
        int n;
        int hold;
        bit aw_hs, w_hs, aw_done, w_done;
        hold = $urandom % 6;
        @(posedge clk);
        aw_valid <= 1'b1;
        aw.addr  <= a;
        w_valid  <= 1'b1;
        w        <= '{data: d, strb: s};
        n = 0;
        aw_done = 1'b0;
        w_done = 1'b0;
        while (!(aw_done && w_done)) begin
            @(negedge clk);
            aw_hs = aw_valid && aw_ready;
            w_hs  = w_valid && w_ready;
            @(posedge clk);
            if (aw_hs) begin
                aw_valid <= 1'b0;
                aw_done = 1'b1;
            end
            if (w_hs) begin
                w_valid <= 1'b0;
                w_done = 1'b1;
            end
            n++;
            if (!(aw_done && w_done) && n > TIMEOUT) stop_run("timeout on aw or w handshake");
        end
        n = 0;
        while (!b_valid) begin
            @(negedge clk);
            n++;
            if (n > TIMEOUT) stop_run("timeout waiting for b_valid");
        end
        repeat (hold) @(posedge clk);
        @(posedge clk);
        b_ready <= 1'b1;
        @(negedge clk);
        pred = ref_reg(a);
        check("b.resp", 32'(b.resp), 32'(pred[1:0]));
        @(posedge clk);
        b_ready <= 1'b0;
        ref_write(a, d, s);
    endtask

    task automatic read_check(input logic [31:0] a);
        logic [31:0] d;
        logic [1:0]  rs;
        logic [33:0] e;
        axi_read(a, d, rs);
        e = ref_reg(a);
        check("r.resp", 32'(rs), 32'(e[1:0]));
        check("r.data", d, e[33:2]);
    endtask

    initial begin
        void'($urandom(SEED));
        rst = 1'b1;
        ar_valid = 1'b0;
        aw_valid = 1'b0;
        w_valid = 1'b0;
        r_ready = 1'b0;
        b_ready = 1'b0;
        ar = '0;
        aw = '0;
        w = '0;
        sh_cmp = '1;
        sh_msip = 1'b0;
        repeat (2) @(posedge clk);
        rst <= 1'b0;

        check("mtip", 32'(mtip), 32'h0);
        check("msip", 32'(msip), 32'h0);
        read_check(A_MSIP);
        read_check(A_CMP_LO);
        read_check(A_CMP_HI);

        repeat (12) begin
            case ($urandom % 3)
                0: addr = A_MSIP;
                1: addr = A_CMP_LO;
                default: addr = A_CMP_HI;
            endcase
            axi_write(addr, $urandom, 4'($urandom));
            check("msip", 32'(msip), 32'(sh_msip));
            read_check(A_MSIP);
            read_check(A_CMP_LO);
            read_check(A_CMP_HI);
        end

        val = $urandom & 32'h7fff_ffff;
        axi_write(A_MT_LO, val, 4'hf);
        axi_write(A_MT_HI, 32'h0, 4'hf);
        axi_read(A_MT_LO, v1, rd_resp);
        check("r.resp", 32'(rd_resp), 32'(`CLINT_RESP_OKAY));
        if (v1 < val || v1 > val + TIMEOUT) stop_run("mtime_lo outside the expected window");
        axi_read(A_MT_LO, rd_data, rd_resp);
        check("r.resp", 32'(rd_resp), 32'(`CLINT_RESP_OKAY));
        if (rd_data < v1) stop_run("mtime_lo went backwards");

        axi_write(A_CMP_LO, 32'hffff_ffff, 4'hf);
        axi_write(A_CMP_HI, 32'h0, 4'hf);
        axi_write(A_MT_LO, 32'd1000, 4'hf);
        axi_write(A_CMP_LO, 32'd1040, 4'hf);
        check("mtip", 32'(mtip), 32'h0);
        cnt = 0;
        while (!mtip) begin
            @(negedge clk);
            cnt++;
            if (cnt > TIMEOUT) stop_run("mtip did not rise after mtime passed mtimecmp");
        end
        axi_write(A_CMP_HI, 32'hffff_ffff, 4'hf);
        axi_write(A_CMP_LO, 32'hffff_ffff, 4'hf);
        check("mtip", 32'(mtip), 32'h0);

        repeat (8) begin
            addr = `CLINT_BASE + (($urandom % `CLINT_SPAN) & 32'hffff_fffc);
            pred = ref_reg(addr);
            if (pred[1:0] == `CLINT_RESP_OKAY) addr = addr + `CLINT_SPAN; // step outside
            axi_write(addr, $urandom, 4'($urandom));
            read_check(addr);
            read_check(A_MSIP);
            read_check(A_CMP_LO);
            read_check(A_CMP_HI);
        end

        $display("*** TEST PASSED ***");
        $finish;
    end

endmodule

`default_nettype wire

//--- tb.f
+incdir+verilog
verilog/clint_axi_pkg.sv
verilog/clint_reg_pkg.sv
verilog/clint_chan_buf.sv
verilog/clint_axi_slave.sv
verilog/clint_timer.sv
verilog/clint_top.sv
dv/clint_properties.sv
dv/clint_tb.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= clint_tb
FILELIST  ?= tb.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert
PASS_STR  ?= *** TEST PASSED ***

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF '$(PASS_STR)'

clean:
	rm -rf $(OBJ_DIR)
